// ==== pipe_hazard_top.f ====
+incdir+include
logic/pipe_ctrl_pkg.sv
logic/operand_decoder.sv
logic/raw_detector.sv
logic/branch_tracker.sv
logic/mem_stall_sync.sv
logic/hazard_unit.sv
logic/pipe_hazard_top.sv
testbench/tb_pipe_hazard_top.sv

// ==== include/tb_hazard_vectors.svh ====
`ifndef TB_HAZARD_VECTORS_SVH
`define TB_HAZARD_VECTORS_SVH

// columns: fetch opcode, decode opcode, rs1, rs2, execute {valid, wr_en, dest, opcode},
// memory {valid, wr_en, dest, opcode}, stalls {instr, data},
// expected {pc_write_disable, if_id_hold, id_ex_hold, ex_nop, mem_nop}
typedef struct packed {
    opcode_t      fetch_opcode;
    decode_info_t decode;
    stage_info_t  ex_stage;
    stage_info_t  mem_stage;
    mem_stall_t   stalls;
    logic [4:0]   expect_comb;
} vector_row_t;

localparam int NUM_VECTORS = 30;

// encodings outside the named set: r-type, 010xx and 101xx immediates
localparam opcode_t op_add  = opcode_t'(5'b11011);
localparam opcode_t op_addi = opcode_t'(5'b01000);
localparam opcode_t op_st   = opcode_t'(5'b10100);

// empty stage, not valid and not writing
localparam logic [10:0] no_stage = 11'h000;

vector_row_t vectors [NUM_VECTORS];

task automatic load_vectors();
    // raw against execute, then execute invalid, then not writing
    vectors[0]  = {op_nop, op_add, 4'h3, 4'h5, 2'b11, 4'h3, op_add, no_stage, 2'b00, 5'b11010};
    vectors[1]  = {op_nop, op_add, 4'h3, 4'h5, 2'b01, 4'h3, op_add, no_stage, 2'b00, 5'b00000};
    vectors[2]  = {op_nop, op_add, 4'h3, 4'h5, 2'b10, 4'h3, op_add, no_stage, 2'b00, 5'b00000};
    // raw against memory on rs2, same three cases
    vectors[3]  = {op_nop, op_add, 4'h3, 4'h5, no_stage, 2'b11, 4'h5, op_ld, 2'b00, 5'b11010};
    vectors[4]  = {op_nop, op_add, 4'h3, 4'h5, no_stage, 2'b01, 4'h5, op_ld, 2'b00, 5'b00000};
    vectors[5]  = {op_nop, op_add, 4'h3, 4'h5, no_stage, 2'b10, 4'h5, op_ld, 2'b00, 5'b00000};
    // rs2 field is an immediate here, dest 5 must not match it
    vectors[6]  = {op_nop, op_addi, 4'h3, 4'h5, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b00000};
    vectors[7]  = {op_nop, op_st, 4'h3, 4'h5, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b00000};
    vectors[8]  = {op_nop, op_ld, 4'h3, 4'h5, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b00000};
    // branch in decode is a control hazard only
    vectors[9]  = {op_nop, op_beqz, 4'h3, 4'h5, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b10000};
    vectors[10] = {op_nop, op_add, 4'h3, 4'h5, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b11010};
    // rs1 not read by lbi and j, but read by jr
    vectors[11] = {op_nop, op_lbi, 4'h5, 4'h0, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b00000};
    vectors[12] = {op_nop, op_j, 4'h5, 4'h0, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b10000};
    vectors[13] = {op_nop, op_jr, 4'h5, 4'h0, 2'b11, 4'h5, op_add, no_stage, 2'b00, 5'b11010};
    // jump or branch in fetch, decode, execute, memory
    vectors[14] = {op_j, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b00, 5'b10000};
    vectors[15] = {op_nop, op_bnez, 4'h0, 4'h0, no_stage, no_stage, 2'b00, 5'b10000};
    vectors[16] = {op_nop, op_nop, 4'h0, 4'h0, 2'b10, 4'h0, op_jal, no_stage, 2'b00, 5'b10000};
    vectors[17] = {op_nop, op_nop, 4'h0, 4'h0, 2'b01, 4'h0, op_jal, no_stage, 2'b00, 5'b00000};
    vectors[18] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, 2'b10, 4'h0, op_bgez, 2'b00, 5'b10000};
    vectors[19] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, 2'b00, 4'h0, op_bgez, 2'b00, 5'b00000};
    // jump plus raw, fetch holds a real instruction and then a nop
    vectors[20] = {op_add, op_add, 4'h3, 4'h5, 2'b11, 4'h3, op_jalr, no_stage, 2'b00, 5'b11010};
    vectors[21] = {op_nop, op_add, 4'h3, 4'h5, 2'b11, 4'h3, op_jalr, no_stage, 2'b00, 5'b11010};
    // halt in fetch stops the pc and nothing else
    vectors[22] = {op_halt, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b00, 5'b10000};
    // data stall held three cycles, then released
    vectors[23] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b01, 5'b11101};
    vectors[24] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b01, 5'b11101};
    vectors[25] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b01, 5'b11101};
    vectors[26] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b00, 5'b00000};
    // instruction stall shows only as a late bubble
    vectors[27] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b10, 5'b00000};
    vectors[28] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b00, 5'b00000};
    vectors[29] = {op_nop, op_nop, 4'h0, 4'h0, no_stage, no_stage, 2'b00, 5'b00000};
endtask

`endif

// ==== testbench/tb_pipe_hazard_top.sv ====
module tb_pipe_hazard_top
    import pipe_ctrl_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_ROWS  = 200;
    localparam int CLK_PERIOD   = 10;

    logic         clk;
    logic         rst_n;
    opcode_t      fetch_opcode;
    decode_info_t decode;
    stage_info_t  ex_stage;
    stage_info_t  mem_stage;
    mem_stall_t   stalls;
    pipe_ctrl_t   ctrl;

    `include "tb_hazard_vectors.svh"

    // model state carried from the previous row
    logic prev_control;
    logic prev_data;
    logic prev_fetch_nop_op;
    logic prev_instr_stall;
    logic prev_data_stall;

    int error_count;
    int test_count;
    int failed_tests;

    pipe_hazard_top pipe_hazard_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_opcode (fetch_opcode),
        .decode       (decode),
        .ex_stage     (ex_stage),
        .mem_stage    (mem_stage),
        .stalls       (stalls),
        .ctrl         (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // rs1 is a real read except for the few formats without a first source
    function automatic logic reads_rs1(input opcode_t op);
        logic used;
        used = 1'b1;
        case (op)
            op_j, op_jal, op_nop, op_lbi, op_halt: used = 1'b0;
            default: used = 1'b1;
        endcase
        return used;
    endfunction

    // rs2 dropped for jumps, branches, both immediate groups and single-source ops
    function automatic logic reads_rs2(input opcode_t op);
        logic used;
        used = 1'b1;
        if (op[4:2] == 3'b001 || op[4:2] == 3'b011) used = 1'b0;
        if (op[4:2] == 3'b010 || op[4:2] == 3'b101) used = 1'b0;
        case (op)
            op_lbi, op_slbi, op_btr, op_nop, op_halt, op_ld: used = 1'b0;
            default: ;
        endcase
        return used;
    endfunction

    // 001xx and 011xx share bit 4 low and bit 2 high
    function automatic logic transfers_control(input opcode_t op);
        return !op[4] && op[2];
    endfunction

    function automatic logic stage_hits(input stage_info_t s, input decode_info_t d);
        logic hit;
        hit = 1'b0;
        if (s.valid && s.wr_en) begin
            if (reads_rs1(d.opcode) && d.rs1 == s.dest) hit = 1'b1;
            if (reads_rs2(d.opcode) && d.rs2 == s.dest) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic data_hazard_of(input vector_row_t r);
        return stage_hits(r.ex_stage, r.decode) || stage_hits(r.mem_stage, r.decode);
    endfunction

    // later stages only count while they hold a valid instruction
    function automatic logic control_hazard_of(input vector_row_t r);
        return transfers_control(r.fetch_opcode) || transfers_control(r.decode.opcode)
            || (r.ex_stage.valid && transfers_control(r.ex_stage.opcode))
            || (r.mem_stage.valid && transfers_control(r.mem_stage.opcode));
    endfunction

    function automatic pipe_ctrl_t predict(input vector_row_t r);
        pipe_ctrl_t p;
        logic dh;
        logic ch;
        logic ds;
        dh = data_hazard_of(r);
        ch = control_hazard_of(r);
        ds = r.stalls.data_stall;
        p.pc_write_disable = dh | ch | (r.fetch_opcode == op_halt) | ds;
        p.if_id_hold       = dh | ds;
        p.id_ex_hold       = ds;
        p.ex_nop           = dh;
        p.mem_nop          = ds;
        // registered bits come from the row before
        p.fetch_nop        = prev_control & (~prev_data | prev_fetch_nop_op);
        p.instr_mem_nop    = prev_instr_stall;
        p.data_mem_nop     = prev_data_stall;
        p.ex_mem_hold      = prev_data_stall;
        return p;
    endfunction

    task automatic check_bit(input string sig, input logic exp_v, input logic act_v);
        assert (act_v === exp_v) else begin
            $display("ERR %s expected %h got %h", sig, exp_v, act_v);
            error_count++;
        end
    endtask

    task automatic check_ctrl(input pipe_ctrl_t exp, input string name);
        int errs_before;
        errs_before = error_count;
        check_bit("pc_write_disable", exp.pc_write_disable, ctrl.pc_write_disable);
        check_bit("fetch_nop", exp.fetch_nop, ctrl.fetch_nop);
        check_bit("if_id_hold", exp.if_id_hold, ctrl.if_id_hold);
        check_bit("id_ex_hold", exp.id_ex_hold, ctrl.id_ex_hold);
        check_bit("ex_nop", exp.ex_nop, ctrl.ex_nop);
        check_bit("ex_mem_hold", exp.ex_mem_hold, ctrl.ex_mem_hold);
        check_bit("mem_nop", exp.mem_nop, ctrl.mem_nop);
        check_bit("instr_mem_nop", exp.instr_mem_nop, ctrl.instr_mem_nop);
        check_bit("data_mem_nop", exp.data_mem_nop, ctrl.data_mem_nop);
        test_count++;
        if (error_count != errs_before) failed_tests++;
        $display("test %0d %s: %s", test_count, name,
                 (error_count == errs_before) ? "pass" : "fail");
    endtask

    // drive on the rising edge, compare at the falling edge
    task automatic run_row(input vector_row_t r, input logic from_table, input string name);
        pipe_ctrl_t exp;
        exp = predict(r);
        if (from_table) begin
            exp.pc_write_disable = r.expect_comb[4];
            exp.if_id_hold       = r.expect_comb[3];
            exp.id_ex_hold       = r.expect_comb[2];
            exp.ex_nop           = r.expect_comb[1];
            exp.mem_nop          = r.expect_comb[0];
        end
        @(posedge clk);
        fetch_opcode <= r.fetch_opcode;
        decode       <= r.decode;
        ex_stage     <= r.ex_stage;
        mem_stage    <= r.mem_stage;
        stalls       <= r.stalls;
        @(negedge clk);
        check_ctrl(exp, name);
        prev_control      = control_hazard_of(r);
        prev_data         = data_hazard_of(r);
        prev_fetch_nop_op = (r.fetch_opcode == op_nop);
        prev_instr_stall  = r.stalls.instr_stall;
        prev_data_stall   = r.stalls.data_stall;
    endtask

    // small register range so random rows actually collide
    function automatic vector_row_t random_row();
        vector_row_t r;
        r.fetch_opcode       = opcode_t'($urandom % 32);
        r.decode.opcode      = opcode_t'($urandom % 32);
        r.decode.rs1         = $urandom % 4;
        r.decode.rs2         = $urandom % 4;
        r.ex_stage.valid     = ($urandom % 4) != 0;
        r.ex_stage.wr_en     = ($urandom % 4) != 0;
        r.ex_stage.dest      = $urandom % 4;
        r.ex_stage.opcode    = opcode_t'($urandom % 32);
        r.mem_stage.valid    = ($urandom % 4) != 0;
        r.mem_stage.wr_en    = ($urandom % 4) != 0;
        r.mem_stage.dest     = $urandom % 4;
        r.mem_stage.opcode   = opcode_t'($urandom % 32);
        r.stalls.instr_stall = ($urandom % 4) == 0;
        r.stalls.data_stall  = ($urandom % 4) == 0;
        r.expect_comb        = 5'b00000;
        return r;
    endfunction

    // watchdog sized from reset, table and random rows
    initial begin
        #((RESET_CYCLES + NUM_VECTORS + RANDOM_ROWS + 10) * 20);
        $display("run timed out before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        void'($urandom(32'h4623));
        load_vectors();
        // busy inputs during reset, nothing may reach the flops
        rst_n        = 1'b0;
        fetch_opcode = op_j;
        decode       = '0;
        ex_stage     = '0;
        mem_stage    = '0;
        stalls       = 2'b11;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n        <= 1'b1;
        fetch_opcode <= op_nop;
        decode       <= {op_nop, 4'h0, 4'h0};
        stalls       <= 2'b00;
        @(negedge clk);
        check_ctrl('0, "reset release");
        prev_control      = 1'b0;
        prev_data         = 1'b0;
        prev_fetch_nop_op = 1'b1;
        prev_instr_stall  = 1'b0;
        prev_data_stall   = 1'b0;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_row(vectors[i], 1'b1, $sformatf("table row %0d", i));
        end
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            run_row(random_row(), 1'b0, $sformatf("random row %0d", i));
        end

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== logic/pipe_hazard_top.sv ====
module pipe_hazard_top
    import pipe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  opcode_t      fetch_opcode,
    input  decode_info_t decode,
    input  stage_info_t  ex_stage,
    input  stage_info_t  mem_stage,
    input  mem_stall_t   stalls,
    output pipe_ctrl_t   ctrl
);

    operand_use_t operand_use;
    logic         data_hazard;
    logic         control_hazard;
    logic         instr_mem_nop;
    logic         data_mem_nop;

    // which decode fields are register reads
    operand_decoder operand_decoder_i (
        .opcode      (decode.opcode),
        .operand_use (operand_use)
    );

    // read after write against execute and memory
    raw_detector raw_detector_i (
        .decode      (decode),
        .operand_use (operand_use),
        .ex_stage    (ex_stage),
        .mem_stage   (mem_stage),
        .data_hazard (data_hazard)
    );

    // jumps and branches anywhere from fetch to memory
    branch_tracker branch_tracker_i (
        .fetch_opcode   (fetch_opcode),
        .decode_opcode  (decode.opcode),
        .ex_stage       (ex_stage),
        .mem_stage      (mem_stage),
        .control_hazard (control_hazard)
    );

    // cache stalls delayed into bubble flags
    mem_stall_sync mem_stall_sync_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stalls        (stalls),
        .instr_mem_nop (instr_mem_nop),
        .data_mem_nop  (data_mem_nop)
    );

    hazard_unit hazard_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_opcode   (fetch_opcode),
        .data_hazard    (data_hazard),
        .control_hazard (control_hazard),
        .stalls         (stalls),
        .instr_mem_nop  (instr_mem_nop),
        .data_mem_nop   (data_mem_nop),
        .ctrl           (ctrl)
    );

endmodule

// ==== logic/hazard_unit.sv ====
module hazard_unit
    import pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  opcode_t    fetch_opcode,
    input  logic       data_hazard,
    input  logic       control_hazard,
    input  mem_stall_t stalls,
    input  logic       instr_mem_nop,
    input  logic       data_mem_nop,
    output pipe_ctrl_t ctrl
);

    // hazard as acted on, suppressed while in reset
    logic raw_active;

    // halt in fetch, pc must not run past it into empty memory
    logic fetch_halt;

    // nop already sitting in fetch
    logic fetch_is_nop;

    // next value of the registered fetch bubble
    logic fetch_nop_d;
    logic fetch_nop_q;

    // combinational controls before packing
    logic pc_write_disable;
    logic if_id_hold;
    logic id_ex_hold;
    logic ex_nop;
    logic ex_mem_hold;
    logic mem_nop;

    assign raw_active   = rst_n & data_hazard;
    assign fetch_halt   = (fetch_opcode == op_halt);
    assign fetch_is_nop = (fetch_opcode == op_nop);

    // pc freezes on any hazard, a halt, or a data cache stall
    assign pc_write_disable = raw_active | control_hazard | fetch_halt
                            | stalls.data_stall;

    // keep the decode instruction in if/id while the bubble goes down,
    // control hazards leave it open so the jump moves on
    assign if_id_hold = raw_active | stalls.data_stall;

    // data cache stall freezes everything up to memory
    assign id_ex_hold = stalls.data_stall;

    // bubble into execute in place of the stalled decode
    assign ex_nop = raw_active;

    // ex/mem held the cycle after a data stall
    assign ex_mem_hold = data_mem_nop;

    // memory issues nothing while its cache is busy
    assign mem_nop = stalls.data_stall;

    // fetch bubble on a control hazard, unless a data hazard holds the
    // decode slot and fetch has something real in it
    assign fetch_nop_d = control_hazard & (~raw_active | fetch_is_nop);

    // fetch bubble applies to the next fetched word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_nop_q <= 1'b0;
        end else begin
            fetch_nop_q <= fetch_nop_d;
        end
    end

    always_comb begin
        ctrl.pc_write_disable = pc_write_disable;
        ctrl.fetch_nop        = fetch_nop_q;
        ctrl.if_id_hold       = if_id_hold;
        ctrl.id_ex_hold       = id_ex_hold;
        ctrl.ex_nop           = ex_nop;
        ctrl.ex_mem_hold      = ex_mem_hold;
        ctrl.mem_nop          = mem_nop;
        ctrl.instr_mem_nop    = instr_mem_nop;
        ctrl.data_mem_nop     = data_mem_nop;
    end

    // a bubble in execute without holding decode would lose an instruction
    a_exnop_holds_ifid: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.ex_nop |-> ctrl.if_id_hold
    ) else $error("ex_nop without if_id_hold");

    // pc must not advance while the data cache stalls
    a_stall_stops_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        stalls.data_stall |-> ctrl.pc_write_disable
    ) else $error("data stall without pc_write_disable");

    // stall seen here comes back through the stall sync a cycle later
    a_stall_holds_exmem: assert property (
        @(posedge clk) disable iff (!rst_n)
        stalls.data_stall |=> ctrl.ex_mem_hold
    ) else $error("ex_mem_hold missing after data stall");

endmodule

// ==== logic/mem_stall_sync.sv ====
module mem_stall_sync
    import pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mem_stall_t stalls,
    output logic       instr_mem_nop,
    output logic       data_mem_nop
);

    // cycle after a cache stall is marked as a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_mem_nop <= 1'b0;
            data_mem_nop  <= 1'b0;
        end else begin
            instr_mem_nop <= stalls.instr_stall;
            data_mem_nop  <= stalls.data_stall;
        end
    end

    // no stale bubble leaks out of reset
    a_clear_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!instr_mem_nop && !data_mem_nop)
    ) else $error("cache bubble flag set in first cycle after reset");

endmodule

// ==== logic/branch_tracker.sv ====
module branch_tracker
    import pipe_ctrl_pkg::*;
(
    input  opcode_t     fetch_opcode,
    input  opcode_t     decode_opcode,
    input  stage_info_t ex_stage,
    input  stage_info_t mem_stage,
    output logic        control_hazard
);

    // one flag per stage holding a jump or branch
    logic fetch_xfer;
    logic decode_xfer;
    logic ex_xfer;
    logic mem_xfer;

    // fetch and decode opcodes are taken as they come
    assign fetch_xfer  = is_ctrl_xfer(fetch_opcode);
    assign decode_xfer = is_ctrl_xfer(decode_opcode);

    // later stages may hold a bubble with a stale opcode
    assign ex_xfer  = ex_stage.valid & is_ctrl_xfer(ex_stage.opcode);
    assign mem_xfer = mem_stage.valid & is_ctrl_xfer(mem_stage.opcode);

    // front of the pipe stays held until the transfer leaves memory
    assign control_hazard = fetch_xfer | decode_xfer | ex_xfer | mem_xfer;

endmodule

// ==== logic/raw_detector.sv ====
module raw_detector
    import pipe_ctrl_pkg::*;
(
    input  decode_info_t decode,
    input  operand_use_t operand_use,
    input  stage_info_t  ex_stage,
    input  stage_info_t  mem_stage,
    output logic         data_hazard
);

    // stage only counts when it holds a real instruction that writes
    logic ex_live;
    logic mem_live;

    // decode reads what the stage is about to write
    logic ex_raw;
    logic mem_raw;

    // true when either used source names the given destination
    function automatic logic reads_dest(
        input logic [REG_IDX_W-1:0] dest,
        input decode_info_t         dec,
        input operand_use_t         src_use
    );
        logic hit_rs1;
        logic hit_rs2;
        hit_rs1 = src_use.use_rs1 && (dec.rs1 == dest);
        hit_rs2 = src_use.use_rs2 && (dec.rs2 == dest);
        return hit_rs1 || hit_rs2;
    endfunction

    assign ex_live  = ex_stage.valid & ex_stage.wr_en;
    assign mem_live = mem_stage.valid & mem_stage.wr_en;

    // execute result is not in the register file yet
    assign ex_raw  = ex_live & reads_dest(ex_stage.dest, decode, operand_use);

    // memory result neither, writeback lands before the read
    assign mem_raw = mem_live & reads_dest(mem_stage.dest, decode, operand_use);

    assign data_hazard = ex_raw | mem_raw;

endmodule

// ==== logic/operand_decoder.sv ====
module operand_decoder
    import pipe_ctrl_pkg::*;
(
    input  opcode_t      opcode,
    output operand_use_t operand_use
);

    // register fields that are really read, so that immediate bits in
    // the rs1/rs2 positions never get compared against a destination
    always_comb begin
        // r-type default, both sources read
        operand_use.use_rs1 = 1'b1;
        operand_use.use_rs2 = 1'b1;

        case (opcode)
            // no register operands at all
            op_halt, op_nop: begin
                operand_use.use_rs1 = 1'b0;
                operand_use.use_rs2 = 1'b0;
            end
            // pc relative jumps, displacement fills both fields
            op_j, op_jal: begin
                operand_use.use_rs1 = 1'b0;
                operand_use.use_rs2 = 1'b0;
            end
            // register jumps read only the base register
            op_jr, op_jalr: begin
                operand_use.use_rs2 = 1'b0;
            end
            // branches test rs1 against zero
            op_beqz, op_bnez, op_bltz, op_bgez: begin
                operand_use.use_rs2 = 1'b0;
            end
            // load byte immediate writes rs1 field, reads nothing
            op_lbi: begin
                operand_use.use_rs1 = 1'b0;
                operand_use.use_rs2 = 1'b0;
            end
            // shift-and-load keeps rs1 as source and destination
            op_slbi: begin
                operand_use.use_rs2 = 1'b0;
            end
            // bit reverse is single source
            op_btr: begin
                operand_use.use_rs2 = 1'b0;
            end
            // load reads only the address base
            op_ld: begin
                operand_use.use_rs2 = 1'b0;
            end
            default: begin
                // anything else keeps the r-type default
            end
        endcase

        // 010xx and 101xx carry an immediate where rs2 would sit
        if (is_imm_group(opcode)) begin
            operand_use.use_rs2 = 1'b0;
        end
    end

endmodule

// ==== logic/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // sixteen architectural registers
    localparam int REG_IDX_W = 4;

    // opcode groups, matched on the upper three opcode bits
    localparam logic [2:0] GRP_JUMP   = 3'b001;
    localparam logic [2:0] GRP_BRANCH = 3'b011;
    localparam logic [2:0] GRP_IMM_A  = 3'b010;
    localparam logic [2:0] GRP_IMM_B  = 3'b101;

    // only the opcodes the hazard logic needs by name
    // any other encoding passes through as a raw 5-bit value
    typedef enum logic [4:0] {
        op_halt = 5'b00000,
        op_nop  = 5'b00001,
        op_j    = 5'b00100,
        op_jr   = 5'b00101,
        op_jal  = 5'b00110,
        op_jalr = 5'b00111,
        op_beqz = 5'b01100,
        op_bnez = 5'b01101,
        op_bltz = 5'b01110,
        op_bgez = 5'b01111,
        op_ld   = 5'b10001,
        op_slbi = 5'b10010,
        op_lbi  = 5'b11000,
        op_btr  = 5'b11001
    } opcode_t;

    // instruction sitting in the if/id latch
    typedef struct packed {
        opcode_t              opcode;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
    } decode_info_t;

    // execute or memory stage as seen by the hazard logic
    typedef struct packed {
        logic                 valid;
        logic                 wr_en;
        logic [REG_IDX_W-1:0] dest;
        opcode_t              opcode;
    } stage_info_t;

    // level stall lines from the two caches
    typedef struct packed {
        logic instr_stall;
        logic data_stall;
    } mem_stall_t;

    // which register fields of the decode instruction are real reads
    typedef struct packed {
        logic use_rs1;
        logic use_rs2;
    } operand_use_t;

    // hold, bubble and pc controls back to the pipeline
    typedef struct packed {
        logic pc_write_disable;
        logic fetch_nop;
        logic if_id_hold;
        logic id_ex_hold;
        logic ex_nop;
        logic ex_mem_hold;
        logic mem_nop;
        logic instr_mem_nop;
        logic data_mem_nop;
    } pipe_ctrl_t;

    // jump or branch, pc not known until it resolves
    function automatic logic is_ctrl_xfer(input opcode_t op);
        logic [2:0] grp;
        grp = op[4:2];
        return (grp == GRP_JUMP) || (grp == GRP_BRANCH);
    endfunction

    // immediate formats with no second register field
    function automatic logic is_imm_group(input opcode_t op);
        logic [2:0] grp;
        grp = op[4:2];
        return (grp == GRP_IMM_A) || (grp == GRP_IMM_B);
    endfunction

endpackage
